/* dispatch_pkg.sv */
// ======================================
// Dispatch package
// Bundle width, micro-op types and the
// RISC-V major opcodes used by decode
// ======================================

package dispatch_pkg;

  localparam int DISPATCH_WIDTH = 4;
  localparam int SEQ_W          = 8;
  localparam int SEL_W          = $clog2(DISPATCH_WIDTH);     // Slot index
  localparam int CNT_W          = $clog2(DISPATCH_WIDTH + 1); // 0 to DISPATCH_WIDTH

  // Target issue queue, value doubles as the class index in dispatch
  typedef enum logic [1:0] {
    IQ_INT  = 2'd0,
    IQ_MEM  = 2'd1,
    IQ_FP   = 2'd2,
    IQ_NONE = 2'd3
  } iq_code_e;

  typedef enum logic [3:0] {
    OP_ALU,
    OP_ALUI,
    OP_LUI,
    OP_BRANCH,
    OP_LOAD,
    OP_STORE,
    OP_FLOAD,
    OP_FSTORE,
    OP_FPU,
    OP_ILLEGAL
  } uop_op_e;

  typedef struct packed {
    logic             valid;
    iq_code_e         iq_code;
    uop_op_e          op;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [31:0]      imm;
    logic [SEQ_W-1:0] seq;
  } micro_op_t;

  // ======================================
  // Major opcodes, instr[6:0]
  // ======================================
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_OP_FP    = 7'b1010011;

endpackage

/* dispatch_if.sv */
// ======================================
// Dispatch to issue queue link
// ======================================

`timescale 1ns/10ps

interface dispatch_if;
  import dispatch_pkg::*;

  micro_op_t [DISPATCH_WIDTH-1:0] uops;  // Packed to the low slots
  logic [CNT_W-1:0]               count; // Filled slots
  logic                           push;
  logic                           room;  // At least a full bundle free

  modport source (
    output uops,
    output count,
    output push,
    input  room
  );

  modport sink (
    input  uops,
    input  count,
    input  push,
    output room
  );

endinterface

/* uop_decoder.sv */
// ======================================
// Micro-op decoder
// Decodes a bundle of instruction words
// into micro-ops, one register stage
// ======================================

`timescale 1ns/10ps

module uop_decoder (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  logic                                                    in_valid,
  output logic                                                    in_ready,
  input  logic [dispatch_pkg::DISPATCH_WIDTH-1:0][31:0]           in_instr,
  output logic                                                    out_valid,
  input  logic                                                    out_ready,
  output dispatch_pkg::micro_op_t [dispatch_pkg::DISPATCH_WIDTH-1:0] out_uops
);
  import dispatch_pkg::*;

  logic [SEQ_W-1:0]               seq_base;
  micro_op_t [DISPATCH_WIDTH-1:0] dec_uops;
  logic                           accept;

  function automatic micro_op_t decode_word(input logic [31:0] instr,
                                            input logic [SEQ_W-1:0] seq);
    micro_op_t   u;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u = {instr[31:12], 12'b0};
    u = '0;
    u.valid = 1'b1;
    u.seq   = seq;
    case (instr[6:0])
      OPC_OP, OPC_OP_FP: begin // R-type
        u.iq_code = (instr[6:0] == OPC_OP) ? IQ_INT : IQ_FP;
        u.op      = (instr[6:0] == OPC_OP) ? OP_ALU : OP_FPU;
        u.rd      = instr[11:7];
        u.rs1     = instr[19:15];
        u.rs2     = instr[24:20];
      end
      OPC_OP_IMM, OPC_LOAD, OPC_LOAD_FP: begin // I-type
        u.iq_code = (instr[6:0] == OPC_OP_IMM) ? IQ_INT : IQ_MEM;
        u.op      = (instr[6:0] == OPC_OP_IMM) ? OP_ALUI :
                    (instr[6:0] == OPC_LOAD)   ? OP_LOAD : OP_FLOAD;
        u.rd      = instr[11:7];
        u.rs1     = instr[19:15];
        u.imm     = imm_i;
      end
      OPC_STORE, OPC_STORE_FP: begin // S-type
        u.iq_code = IQ_MEM;
        u.op      = (instr[6:0] == OPC_STORE) ? OP_STORE : OP_FSTORE;
        u.rs1     = instr[19:15];
        u.rs2     = instr[24:20];
        u.imm     = imm_s;
      end
      OPC_BRANCH: begin
        u.iq_code = IQ_INT;
        u.op      = OP_BRANCH;
        u.rs1     = instr[19:15];
        u.rs2     = instr[24:20];
        u.imm     = imm_b;
      end
      OPC_LUI: begin
        u.iq_code = IQ_INT;
        u.op      = OP_LUI;
        u.rd      = instr[11:7];
        u.imm     = imm_u;
      end
      default: begin
        // Dropped here, sequence number still consumed
        u.valid   = 1'b0;
        u.iq_code = IQ_NONE;
        u.op      = OP_ILLEGAL;
      end
    endcase
    return u;
  endfunction

  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      dec_uops[i] = decode_word(in_instr[i], seq_base + SEQ_W'(i));
    end
  end

  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      seq_base  <= '0;
    end else begin
      if (accept) begin
        out_valid <= 1'b1;
        seq_base  <= seq_base + SEQ_W'(DISPATCH_WIDTH); // Wraps at 256
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_uops <= dec_uops;
    end
  end

endmodule

/* dispatch_selector.sv */
// ======================================
// Dispatch selector
// Slot k picks the k-th set request bit
// ======================================

`timescale 1ns/10ps

module dispatch_selector (
  input  logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                          req,
  output logic [dispatch_pkg::DISPATCH_WIDTH-1:0][dispatch_pkg::SEL_W-1:0] sel,
  output logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                          sel_valid
);
  import dispatch_pkg::*;

  always_comb begin
    logic [DISPATCH_WIDTH-1:0] remain;
    remain = req;
    for (int k = 0; k < DISPATCH_WIDTH; k++) begin
      sel[k]       = '0;
      sel_valid[k] = 1'b0;
      // Scan downward so the lowest set bit wins
      for (int j = DISPATCH_WIDTH - 1; j >= 0; j--) begin
        if (remain[j]) begin
          sel[k]       = SEL_W'(j);
          sel_valid[k] = 1'b1;
        end
      end
      if (sel_valid[k]) begin
        remain[sel[k]] = 1'b0; // Taken by this slot
      end
    end
  end

endmodule

/* dispatch.sv */
// ======================================
// Dispatch
// Sorts decoded micro-ops by issue queue
// and packs each class to the low slots
// ======================================

`timescale 1ns/10ps

module dispatch (
  input  logic                                                    in_valid,
  output logic                                                    in_ready,
  input  dispatch_pkg::micro_op_t [dispatch_pkg::DISPATCH_WIDTH-1:0] in_uops,
  dispatch_if.source                                              to_int,
  dispatch_if.source                                              to_mem,
  dispatch_if.source                                              to_fp
);
  import dispatch_pkg::*;

  localparam int NUM_Q = 3; // Indexed by iq_code_e

  logic [NUM_Q-1:0][DISPATCH_WIDTH-1:0]            req;
  logic [NUM_Q-1:0][DISPATCH_WIDTH-1:0][SEL_W-1:0] sel;
  logic [NUM_Q-1:0][DISPATCH_WIDTH-1:0]            sel_valid;
  micro_op_t [NUM_Q-1:0][DISPATCH_WIDTH-1:0]       q_uops;
  logic [NUM_Q-1:0][CNT_W-1:0]                     q_count;
  logic                                            push;

  // Request masks per class
  always_comb begin
    for (int q = 0; q < NUM_Q; q++) begin
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        req[q][i] = in_uops[i].valid && (in_uops[i].iq_code == iq_code_e'(q));
      end
    end
  end

  for (genvar q = 0; q < NUM_Q; q++) begin : g_class
    dispatch_selector class_selector (
      .req       (req[q]),
      .sel       (sel[q]),
      .sel_valid (sel_valid[q])
    );
  end

  // ======================================
  // Compaction and slot count
  // ======================================
  always_comb begin
    for (int q = 0; q < NUM_Q; q++) begin
      q_count[q] = '0;
      for (int k = 0; k < DISPATCH_WIDTH; k++) begin
        q_uops[q][k] = sel_valid[q][k] ? in_uops[sel[q][k]] : '0;
        q_count[q]   = q_count[q] + CNT_W'(sel_valid[q][k]);
      end
    end
  end

  // Whole bundle moves at once or not at all
  assign in_ready = to_int.room && to_mem.room && to_fp.room;
  assign push     = in_valid && in_ready;

  assign to_int.uops  = q_uops[IQ_INT];
  assign to_int.count = q_count[IQ_INT];
  assign to_int.push  = push;

  assign to_mem.uops  = q_uops[IQ_MEM];
  assign to_mem.count = q_count[IQ_MEM];
  assign to_mem.push  = push;

  assign to_fp.uops   = q_uops[IQ_FP];
  assign to_fp.count  = q_count[IQ_FP];
  assign to_fp.push   = push;

endmodule

/* issue_queue.sv */
// ======================================
// Issue queue
// Circular buffer, up to a bundle in and
// one micro-op out per cycle
// ======================================

`timescale 1ns/10ps

module issue_queue #(
  parameter int IQ_DEPTH = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    deq_ready,
  dispatch_if.sink                enq,
  output logic                    deq_valid,
  output dispatch_pkg::micro_op_t deq_uop
);
  import dispatch_pkg::*;

  localparam int PTR_W = $clog2(IQ_DEPTH);

  micro_op_t        entries [IQ_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0]   occ;   // Occupancy, 0 to IQ_DEPTH
  logic [CNT_W-1:0] n_enq;
  logic             do_deq;

  assign n_enq  = enq.push ? enq.count : '0;
  assign do_deq = deq_valid && deq_ready;

  // Room for a full bundle, independent of push
  assign enq.room = occ <= (PTR_W + 1)'(IQ_DEPTH - DISPATCH_WIDTH);

  assign deq_valid = occ != '0;
  assign deq_uop   = entries[head];

  // ======================================
  // Storage
  // ======================================
  always_ff @(posedge clk) begin
    if (enq.push) begin
      for (int k = 0; k < DISPATCH_WIDTH; k++) begin
        if (CNT_W'(k) < enq.count) begin
          entries[tail + PTR_W'(k)] <= enq.uops[k]; // Program order kept
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
      occ  <= '0;
    end else begin
      tail <= tail + PTR_W'(n_enq);
      occ  <= occ + (PTR_W + 1)'(n_enq) - (PTR_W + 1)'(do_deq);
      if (do_deq) begin
        head <= head + 1'b1;
      end
    end
  end

endmodule

/* dispatch_unit_top.sv */
// ======================================
// Dispatch unit top
// Decoder, dispatch and three issue queues
// ======================================

`timescale 1ns/10ps

module dispatch_unit_top #(
  parameter int IQ_DEPTH = 8
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  // Instruction bundle in
  input  logic                                          in_valid,
  output logic                                          in_ready,
  input  logic [dispatch_pkg::DISPATCH_WIDTH-1:0][31:0] in_instr,
  // Integer queue out
  output logic                                          int_valid,
  input  logic                                          int_ready,
  output dispatch_pkg::micro_op_t                       int_uop,
  // Memory queue out
  output logic                                          mem_valid,
  input  logic                                          mem_ready,
  output dispatch_pkg::micro_op_t                       mem_uop,
  // Floating point queue out
  output logic                                          fp_valid,
  input  logic                                          fp_ready,
  output dispatch_pkg::micro_op_t                       fp_uop
);
  import dispatch_pkg::*;

  micro_op_t [DISPATCH_WIDTH-1:0] dec_uops;
  logic                           dec_valid;
  logic                           dec_ready;

  dispatch_if if_int ();
  dispatch_if if_mem ();
  dispatch_if if_fp ();

  uop_decoder u_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_instr  (in_instr),
    .out_valid (dec_valid),
    .out_ready (dec_ready),
    .out_uops  (dec_uops)
  );

  dispatch u_dispatch (
    .in_valid (dec_valid),
    .in_ready (dec_ready),
    .in_uops  (dec_uops),
    .to_int   (if_int.source),
    .to_mem   (if_mem.source),
    .to_fp    (if_fp.source)
  );

  issue_queue #(.IQ_DEPTH(IQ_DEPTH)) u_iq_int (
    .clk       (clk),
    .rst_n     (rst_n),
    .deq_ready (int_ready),
    .enq       (if_int.sink),
    .deq_valid (int_valid),
    .deq_uop   (int_uop)
  );

  issue_queue #(.IQ_DEPTH(IQ_DEPTH)) u_iq_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .deq_ready (mem_ready),
    .enq       (if_mem.sink),
    .deq_valid (mem_valid),
    .deq_uop   (mem_uop)
  );

  issue_queue #(.IQ_DEPTH(IQ_DEPTH)) u_iq_fp (
    .clk       (clk),
    .rst_n     (rst_n),
    .deq_ready (fp_ready),
    .enq       (if_fp.sink),
    .deq_valid (fp_valid),
    .deq_uop   (fp_uop)
  );

endmodule

/* dispatch_unit_sva.sv */
// ========================================
// Issue queue assertions
// Push against room, occupancy bound and
// output stability under back-pressure
// ========================================

`timescale 1ns/10ps

module issue_queue_sva #(
  parameter int IQ_DEPTH = 8
) (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        push,
  input logic                        room,
  input logic [$clog2(IQ_DEPTH):0]   occ,
  input logic                        deq_valid,
  input logic                        deq_ready,
  input dispatch_pkg::micro_op_t     deq_uop
);

  localparam int OCC_W = $clog2(IQ_DEPTH) + 1;

  a_push_room: assert property (@(posedge clk) disable iff (!rst_n) push |-> room)
    else $error("issue queue pushed while room was low");

  a_occ_bound: assert property (@(posedge clk) disable iff (!rst_n) occ <= OCC_W'(IQ_DEPTH))
    else $error("issue queue occupancy above depth");

  // Waiting output holds until taken
  a_deq_stable: assert property (@(posedge clk) disable iff (!rst_n)
    deq_valid && !deq_ready |=> deq_valid && $stable(deq_uop))
    else $error("issue queue output changed while waiting");

endmodule

bind issue_queue issue_queue_sva #(.IQ_DEPTH(IQ_DEPTH)) sva_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .push      (enq.push),
  .room      (enq.room),
  .occ       (occ),
  .deq_valid (deq_valid),
  .deq_ready (deq_ready),
  .deq_uop   (deq_uop)
);

/* tb_dispatch_unit.sv */
// ========================================
// Dispatch unit testbench
// Table and random bundles checked against
// a reference decode model
// ========================================

`timescale 1ns/10ps

module tb_dispatch_unit;
  import dispatch_pkg::*;

  localparam int NUM_ROWS    = 11;
  localparam int NUM_RAND    = 40;
  localparam int NUM_BUNDLES = NUM_ROWS + NUM_RAND;
  localparam int UW          = $bits(micro_op_t);

  logic                            clk;
  logic                            rst_n;
  logic                            in_valid;
  logic                            in_ready;
  logic [DISPATCH_WIDTH-1:0][31:0] in_instr;
  logic                            int_valid;
  logic                            int_ready;
  micro_op_t                       int_uop;
  logic                            mem_valid;
  logic                            mem_ready;
  micro_op_t                       mem_uop;
  logic                            fp_valid;
  logic                            fp_ready;
  micro_op_t                       fp_uop;

  string                           row_name  [$];
  logic [DISPATCH_WIDTH-1:0][31:0] row_words [$];
  logic [2:0]                      row_hold  [$]; // {fp, mem, int} forced not ready
  micro_op_t                       exp_int   [$];
  micro_op_t                       exp_mem   [$];
  micro_op_t                       exp_fp    [$];
  logic [2:0]                      hold;
  logic                            stall_seen;
  logic [SEQ_W-1:0]                model_seq  = '0;
  logic [31:0]                     stim_state = 32'd40636;
  logic [31:0]                     rdy_state  = 32'd40636;
  string                           cur_name;
  logic [6:0]                      opc_list [10];

  dispatch_unit_top #(.IQ_DEPTH(8)) dispatch_unit_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_instr  (in_instr),
    .int_valid (int_valid),
    .int_ready (int_ready),
    .int_uop   (int_uop),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_uop   (mem_uop),
    .fp_valid  (fp_valid),
    .fp_ready  (fp_ready),
    .fp_uop    (fp_uop)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected micro-op for one instruction word
  function automatic micro_op_t ref_uop(input logic [31:0] w, input logic [SEQ_W-1:0] seq);
    micro_op_t u;
    u     = '0;
    u.seq = seq;
    case (w[6:0])
      7'h33:   u.op = OP_ALU;
      7'h13:   u.op = OP_ALUI;
      7'h37:   u.op = OP_LUI;
      7'h63:   u.op = OP_BRANCH;
      7'h03:   u.op = OP_LOAD;
      7'h23:   u.op = OP_STORE;
      7'h07:   u.op = OP_FLOAD;
      7'h27:   u.op = OP_FSTORE;
      7'h53:   u.op = OP_FPU;
      default: u.op = OP_ILLEGAL;
    endcase
    case (u.op)
      OP_ALU, OP_ALUI, OP_LUI, OP_BRANCH:     u.iq_code = IQ_INT;
      OP_LOAD, OP_STORE, OP_FLOAD, OP_FSTORE: u.iq_code = IQ_MEM;
      OP_FPU:                                 u.iq_code = IQ_FP;
      default:                                u.iq_code = IQ_NONE;
    endcase
    u.valid = (u.op != OP_ILLEGAL);
    // Register fields by format
    if (u.op inside {OP_ALU, OP_ALUI, OP_LUI, OP_LOAD, OP_FLOAD, OP_FPU}) u.rd = w[11:7];
    if (!(u.op inside {OP_LUI, OP_ILLEGAL})) u.rs1 = w[19:15];
    if (u.op inside {OP_ALU, OP_FPU, OP_BRANCH, OP_STORE, OP_FSTORE}) u.rs2 = w[24:20];
    case (u.op)
      OP_ALUI, OP_LOAD, OP_FLOAD: u.imm = {{20{w[31]}}, w[31:20]};
      OP_STORE, OP_FSTORE:        u.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      OP_BRANCH:                  u.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      OP_LUI:                     u.imm = {w[31:12], 12'h000};
      default:                    u.imm = '0;
    endcase
    return u;
  endfunction

  task automatic check(input string name, input logic [UW-1:0] exp, input logic [UW-1:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic unexpected_output(input string cls);
    $display("A micro-op left the %s queue with nothing expected", cls);
    $display("Done: errors found");
    $fatal(1, "unexpected output");
  endtask

  task automatic add_row(input string name, input logic [2:0] hold_mask, input logic [31:0] w0,
                         input logic [31:0] w1, input logic [31:0] w2, input logic [31:0] w3);
    row_name.push_back(name);
    row_hold.push_back(hold_mask);
    row_words.push_back({w3, w2, w1, w0});
  endtask

  task automatic model_accept(input logic [DISPATCH_WIDTH-1:0][31:0] words);
    micro_op_t u;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      u = ref_uop(words[i], model_seq + SEQ_W'(i));
      if (u.iq_code == IQ_INT) exp_int.push_back(u);
      if (u.iq_code == IQ_MEM) exp_mem.push_back(u);
      if (u.iq_code == IQ_FP) exp_fp.push_back(u);
    end
    model_seq = model_seq + SEQ_W'(DISPATCH_WIDTH); // Illegal slots use theirs too
  endtask

  // Called at a falling edge, returns one falling edge after acceptance
  task automatic send_bundle(input logic [DISPATCH_WIDTH-1:0][31:0] words);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    in_instr = words;
    while (!in_ready) begin
      @(negedge clk);
      waited++;
      if (waited > 12 && hold != 3'b000) begin
        stall_seen = 1'b1; // Back-pressure reached the input, let the output drain
        hold       = 3'b000;
      end
    end
    @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Output ready bits, low about a third of the time
  always @(negedge clk) begin
    logic [2:0] r;
    for (int q = 0; q < 3; q++) begin
      rdy_state = xorshift(rdy_state);
      r[q]      = !hold[q] && (rdy_state % 32'd3 != 32'd0);
    end
    int_ready = r[0];
    mem_ready = r[1];
    fp_ready  = r[2];
  end

  // ========================================
  // Reference model and output checks
  // ========================================
  always @(posedge clk) begin
    if (rst_n) begin
      if (in_valid && in_ready) model_accept(in_instr);
      if (int_valid && int_ready) begin
        if (exp_int.size() == 0) unexpected_output("integer");
        else check(cur_name, exp_int.pop_front(), int_uop);
      end
      if (mem_valid && mem_ready) begin
        if (exp_mem.size() == 0) unexpected_output("memory");
        else check(cur_name, exp_mem.pop_front(), mem_uop);
      end
      if (fp_valid && fp_ready) begin
        if (exp_fp.size() == 0) unexpected_output("floating point");
        else check(cur_name, exp_fp.pop_front(), fp_uop);
      end
    end
  end

  initial begin
    repeat (16 + NUM_BUNDLES * DISPATCH_WIDTH * 20) @(posedge clk);
    $display("Watchdog expired, the outputs stalled before all micro-ops arrived");
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  initial begin
    logic [DISPATCH_WIDTH-1:0][31:0] words;
    logic [31:0]                     r;
    int                              idx;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_instr   = '0;
    int_ready  = 1'b0;
    mem_ready  = 1'b0;
    fp_ready   = 1'b0;
    hold       = 3'b000;
    stall_seen = 1'b0;
    cur_name   = "reset";
    // OP, OP-IMM, LUI, BRANCH, LOAD, STORE, LOAD-FP, STORE-FP, OP-FP, illegal
    opc_list = '{7'h33, 7'h13, 7'h37, 7'h63, 7'h03, 7'h23, 7'h07, 7'h27, 7'h53, 7'h7f};

    add_row("all_classes", 3'b000, 32'h00b50533, 32'hfff00293, 32'h01012303, 32'h0030f153);
    add_row("int_four", 3'b000, 32'h123453b7, 32'hfe208ce3, 32'h00b50533, 32'hfff00293);
    add_row("mem_four", 3'b000, 32'h01012303, 32'hfe612e23, 32'h0081a087, 32'h0011a627);
    add_row("fp_four", 3'b000, 32'h0030f153, 32'h20208053, 32'h1030f0d3, 32'h00000053);
    add_row("illegal_mix", 3'b000, 32'h0000007f, 32'h00b50533, 32'h00000000, 32'h0011a627);
    add_row("all_illegal", 3'b000, 32'hffffffff, 32'h0000000b, 32'h0000007f, 32'h00000000);
    repeat (5) begin
      add_row("int_stall", 3'b001, 32'h00b50533, 32'hfff00293, 32'h123453b7, 32'hfe208ce3);
    end

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check("reset", UW'(3'b000), UW'({int_valid, mem_valid, fp_valid}));
    check("reset", UW'(1'b1), UW'(in_ready));

    for (int n = 0; n < row_name.size(); n++) begin
      cur_name = row_name[n];
      hold     = row_hold[n];
      send_bundle(row_words[n]);
    end
    hold     = 3'b000;
    cur_name = "random";
    for (int n = 0; n < NUM_RAND; n++) begin
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        stim_state = xorshift(stim_state);
        r          = stim_state;
        stim_state = xorshift(stim_state);
        idx        = int'(stim_state % 32'd10);
        words[i]   = {r[31:7], opc_list[idx]};
      end
      send_bundle(words);
    end
    in_valid = 1'b0;
    check("int_stall", UW'(1'b1), UW'(stall_seen));

    while (exp_int.size() + exp_mem.size() + exp_fp.size() != 0) @(negedge clk);
    repeat (10) @(negedge clk); // Catch any stray output
    $display("Done: no errors");
    $finish;
  end

endmodule

/* src.f */
dispatch_pkg.sv
dispatch_if.sv
uop_decoder.sv
dispatch_selector.sv
dispatch.sv
issue_queue.sv
dispatch_unit_top.sv
dispatch_unit_sva.sv
tb_dispatch_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the dispatch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_dispatch_unit -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
